// ==== verilog/tlb_cfg.svh ====
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// joint tlb geometry
`define TLB_ENTRIES 16
`define TLB_IDX_W   4

// field widths
`define VPN2_W      19  // vaddr[31:13]
`define PFN_W       20
`define ASID_W      8

// cp0 register numbers for the tlb side
`define CP0_INDEX    5'd0
`define CP0_RANDOM   5'd1
`define CP0_ENTRYLO0 5'd2
`define CP0_ENTRYLO1 5'd3
`define CP0_ENTRYHI  5'd10

`endif

// ==== verilog/tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

    `include "tlb_cfg.svh"

    typedef logic [`VPN2_W-1:0]    vpn2_t;
    typedef logic [`ASID_W-1:0]    asid_t;
    typedef logic [`PFN_W-1:0]     pfn_t;
    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;
    typedef logic [2:0]            cattr_t;  // cache attribute

    // one half of an entry
    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d;   // dirty, i.e. writable
        logic   v;
    } tlb_page_t;

    // even page maps vaddr[12] == 0
    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;
        tlb_page_t even_pg;
        tlb_page_t odd_pg;
    } tlb_entry_t;

endpackage

`default_nettype wire

// ==== verilog/tlb_match.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_match (
    input  tlb_pkg::tlb_entry_t entries [`TLB_ENTRIES],
    input  tlb_pkg::vpn2_t      vpn2,
    input  tlb_pkg::asid_t      asid,
    input  logic                odd,
    output logic                found,
    output tlb_pkg::tlb_idx_t   idx,
    output tlb_pkg::tlb_page_t  page
);

    import tlb_pkg::*;

    logic [`TLB_ENTRIES-1:0] hit;

    // per-entry compare, global bit masks the asid
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            hit[i] = (entries[i].vpn2 == vpn2) &&
                     (entries[i].g || (entries[i].asid == asid));
        end
    end

    // scanning downward leaves the lowest hit in idx
    always_comb begin
        found = 1'b0;
        idx   = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                found = 1'b1;
                idx   = tlb_idx_t'(i);
            end
        end
    end

    // half of the pair picked by vaddr[12]
    always_comb begin
        if (odd) begin
            page = entries[idx].odd_pg;
        end else begin
            page = entries[idx].even_pg;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tlb_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_array (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                we,
    input  tlb_pkg::tlb_idx_t   widx,
    input  tlb_pkg::tlb_entry_t wentry,
    input  logic [31:0]         inst_vaddr,
    input  logic [31:0]         data_vaddr,
    input  tlb_pkg::asid_t      cur_asid,
    input  tlb_pkg::vpn2_t      probe_vpn2,
    output logic [31:0]         inst_paddr,
    output logic [31:0]         data_paddr,
    output logic                inst_found,
    output logic                inst_v,
    output logic                inst_d,
    output tlb_pkg::cattr_t     inst_c,
    output logic                data_found,
    output logic                data_v,
    output logic                data_d,
    output tlb_pkg::cattr_t     data_c,
    output logic                probe_found,
    output tlb_pkg::tlb_idx_t   probe_idx
);

    import tlb_pkg::*;

    tlb_entry_t entries [`TLB_ENTRIES];
    tlb_page_t  inst_page;
    tlb_page_t  data_page;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[widx] <= wentry;
        end
    end

    tlb_match u_inst_match (
        .entries (entries),
        .vpn2    (inst_vaddr[31:13]),
        .asid    (cur_asid),
        .odd     (inst_vaddr[12]),
        .found   (inst_found),
        .idx     (),
        .page    (inst_page)
    );

    tlb_match u_data_match (
        .entries (entries),
        .vpn2    (data_vaddr[31:13]),
        .asid    (cur_asid),
        .odd     (data_vaddr[12]),
        .found   (data_found),
        .idx     (),
        .page    (data_page)
    );

    // probe wants the index only
    tlb_match u_probe_match (
        .entries (entries),
        .vpn2    (probe_vpn2),
        .asid    (cur_asid),
        .odd     (1'b0),
        .found   (probe_found),
        .idx     (probe_idx),
        .page    ()
    );

    assign inst_paddr = {inst_page.pfn, inst_vaddr[11:0]};
    assign inst_v     = inst_page.v;
    assign inst_d     = inst_page.d;
    assign inst_c     = inst_page.c;

    assign data_paddr = {data_page.pfn, data_vaddr[11:0]};
    assign data_v     = data_page.v;
    assign data_d     = data_page.d;
    assign data_c     = data_page.c;

endmodule

`default_nettype wire

// ==== verilog/tlb_cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_cp0_regs (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                cp0_wen,
    input  logic [4:0]          cp0_waddr,
    input  logic [31:0]         cp0_wdata,
    input  logic [4:0]          cp0_raddr,
    output logic [31:0]         cp0_rdata,
    input  logic                op_tlbwi,
    input  logic                op_tlbwr,
    input  logic                op_tlbp,
    input  logic                probe_found,
    input  tlb_pkg::tlb_idx_t   probe_idx,
    output logic                we,
    output tlb_pkg::tlb_idx_t   widx,
    output tlb_pkg::tlb_entry_t wentry,
    output tlb_pkg::asid_t      cur_asid,
    output tlb_pkg::vpn2_t      probe_vpn2
);

    import tlb_pkg::*;

    logic      index_p;    // probe failed
    tlb_idx_t  index_val;
    tlb_idx_t  random;
    vpn2_t     hi_vpn2;
    asid_t     hi_asid;
    tlb_page_t lo0;
    tlb_page_t lo1;
    logic      lo0_g;
    logic      lo1_g;

    // EntryLo layout: pfn 25..6, c 5..3, d 2, v 1, g 0
    function automatic tlb_page_t lo_page(input logic [31:0] w);
        lo_page = {w[25:6], w[5:3], w[2], w[1]};
    endfunction

    function automatic logic [31:0] lo_word(input tlb_page_t p, input logic g);
        lo_word = {6'b0, p.pfn, p.c, p.d, p.v, g};
    endfunction

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            index_p   <= 1'b0;
            index_val <= '0;
            hi_vpn2   <= '0;
            hi_asid   <= '0;
            lo0       <= '0;
            lo1       <= '0;
            lo0_g     <= 1'b0;
            lo1_g     <= 1'b0;
        end else begin
            if (cp0_wen) begin
                case (cp0_waddr)
                    `CP0_INDEX: begin
                        index_p   <= cp0_wdata[31];
                        index_val <= cp0_wdata[3:0];
                    end
                    `CP0_ENTRYLO0: begin
                        lo0   <= lo_page(cp0_wdata);
                        lo0_g <= cp0_wdata[0];
                    end
                    `CP0_ENTRYLO1: begin
                        lo1   <= lo_page(cp0_wdata);
                        lo1_g <= cp0_wdata[0];
                    end
                    `CP0_ENTRYHI: begin
                        hi_vpn2 <= cp0_wdata[31:13];
                        hi_asid <= cp0_wdata[7:0];
                    end
                    default: ;  // Random is read only
                endcase
            end
            if (op_tlbp) begin
                index_p <= ~probe_found;
                if (probe_found) begin
                    index_val <= probe_idx;
                end
            end
        end
    end

    // free running down counter, wraps 0 -> 15
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            random <= tlb_idx_t'(`TLB_ENTRIES - 1);
        end else begin
            random <= random - 1'b1;
        end
    end

    always_comb begin
        case (cp0_raddr)
            `CP0_INDEX:    cp0_rdata = {index_p, 27'b0, index_val};
            `CP0_RANDOM:   cp0_rdata = {28'b0, random};
            `CP0_ENTRYLO0: cp0_rdata = lo_word(lo0, lo0_g);
            `CP0_ENTRYLO1: cp0_rdata = lo_word(lo1, lo1_g);
            `CP0_ENTRYHI:  cp0_rdata = {hi_vpn2, 5'b0, hi_asid};
            default:       cp0_rdata = 32'b0;
        endcase
    end

    assign we   = op_tlbwi | op_tlbwr;
    assign widx = op_tlbwi ? index_val : random;  // tlbwi first

    assign wentry = '{vpn2: hi_vpn2, asid: hi_asid, g: lo0_g & lo1_g,
                      even_pg: lo0, odd_pg: lo1};

    assign cur_asid   = hi_asid;
    assign probe_vpn2 = hi_vpn2;

endmodule

`default_nettype wire

// ==== verilog/tlb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_top (
    input  logic            aclk,
    input  logic            rst_n,
    input  logic [31:0]     inst_vaddr,
    output logic [31:0]     inst_paddr,
    output logic            inst_found,
    output logic            inst_v,
    output logic            inst_d,
    output tlb_pkg::cattr_t inst_c,
    input  logic [31:0]     data_vaddr,
    output logic [31:0]     data_paddr,
    output logic            data_found,
    output logic            data_v,
    output logic            data_d,
    output tlb_pkg::cattr_t data_c,
    input  logic            cp0_wen,
    input  logic [4:0]      cp0_waddr,
    input  logic [31:0]     cp0_wdata,
    input  logic [4:0]      cp0_raddr,
    output logic [31:0]     cp0_rdata,
    input  logic            op_tlbwi,
    input  logic            op_tlbwr,
    input  logic            op_tlbp
);

    import tlb_pkg::*;

    logic       we;
    tlb_idx_t   widx;
    tlb_entry_t wentry;
    asid_t      cur_asid;
    vpn2_t      probe_vpn2;
    logic       probe_found;
    tlb_idx_t   probe_idx;

    tlb_cp0_regs u_regs (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .cp0_wen     (cp0_wen),
        .cp0_waddr   (cp0_waddr),
        .cp0_wdata   (cp0_wdata),
        .cp0_raddr   (cp0_raddr),
        .cp0_rdata   (cp0_rdata),
        .op_tlbwi    (op_tlbwi),
        .op_tlbwr    (op_tlbwr),
        .op_tlbp     (op_tlbp),
        .probe_found (probe_found),
        .probe_idx   (probe_idx),
        .we          (we),
        .widx        (widx),
        .wentry      (wentry),
        .cur_asid    (cur_asid),
        .probe_vpn2  (probe_vpn2)
    );

    tlb_array u_array (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .we          (we),
        .widx        (widx),
        .wentry      (wentry),
        .inst_vaddr  (inst_vaddr),
        .data_vaddr  (data_vaddr),
        .cur_asid    (cur_asid),
        .probe_vpn2  (probe_vpn2),
        .inst_paddr  (inst_paddr),
        .data_paddr  (data_paddr),
        .inst_found  (inst_found),
        .inst_v      (inst_v),
        .inst_d      (inst_d),
        .inst_c      (inst_c),
        .data_found  (data_found),
        .data_v      (data_v),
        .data_d      (data_d),
        .data_c      (data_c),
        .probe_found (probe_found),
        .probe_idx   (probe_idx)
    );

endmodule

`default_nettype wire

// ==== bench/tlb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tlb_cfg.svh"

module tlb_tb;

    import tlb_pkg::*;

    localparam int N_TESTS = 6;

    logic        aclk = 1'b0;
    logic        rst_n;
    logic [31:0] inst_vaddr;
    logic [31:0] inst_paddr;
    logic        inst_found;
    logic        inst_v;
    logic        inst_d;
    cattr_t      inst_c;
    logic [31:0] data_vaddr;
    logic [31:0] data_paddr;
    logic        data_found;
    logic        data_v;
    logic        data_d;
    cattr_t      data_c;
    logic        cp0_wen;
    logic [4:0]  cp0_waddr;
    logic [31:0] cp0_wdata;
    logic [4:0]  cp0_raddr;
    logic [31:0] cp0_rdata;
    logic        op_tlbwi;
    logic        op_tlbwr;
    logic        op_tlbp;

    string     cur_test;
    int        test_errs;
    int        n_pass = 0;
    int        n_fail = 0;
    vpn2_t     map_vpn2;   // non-global mapping shared by later tests
    asid_t     map_asid;
    tlb_idx_t  map_idx;
    tlb_page_t map_even;
    tlb_page_t map_odd;

    tlb_top i_tlb_top (.*);

    always #20 aclk = ~aclk;

    // 200 cycles per test
    initial begin
        #(N_TESTS * 200 * 40);
        $display("timeout: tests did not finish within %0d cycles", N_TESTS * 200);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_idx(input string what, input tlb_idx_t exp, input tlb_idx_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_attr(input string what, input cattr_t exp, input cattr_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s: passed", cur_test);
            n_pass++;
        end else begin
            $display("test %s: %0d mismatches", cur_test, test_errs);
            n_fail++;
        end
    endtask

    task automatic cp0_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge aclk);
        cp0_wen   <= 1'b1;
        cp0_waddr <= addr;
        cp0_wdata <= data;
        @(posedge aclk);
        cp0_wen   <= 1'b0;
    endtask

    // sampled mid-cycle
    task automatic cp0_read(input logic [4:0] addr, output logic [31:0] data);
        @(posedge aclk);
        cp0_raddr <= addr;
        #20;
        data = cp0_rdata;
    endtask

    task automatic pulse_ops(input logic wi, input logic wr, input logic p);
        @(posedge aclk);
        op_tlbwi <= wi;
        op_tlbwr <= wr;
        op_tlbp  <= p;
        @(posedge aclk);
        op_tlbwi <= 1'b0;
        op_tlbwr <= 1'b0;
        op_tlbp  <= 1'b0;
    endtask

    task automatic translate(input logic [31:0] iva, input logic [31:0] dva);
        @(posedge aclk);
        inst_vaddr <= iva;
        data_vaddr <= dva;
        #20;
    endtask

    // tag in the top bits keeps each test's pair apart, and never zero
    function automatic vpn2_t rand_vpn2(input int tag);
        return vpn2_t'((tag << 16) | ($urandom & 32'hffff));
    endfunction

    function automatic tlb_page_t rand_page();
        tlb_page_t p;
        p.pfn = pfn_t'($urandom);
        p.c   = cattr_t'($urandom);
        p.d   = $urandom % 2;
        p.v   = $urandom % 2;
        return p;
    endfunction

    // EntryLo: pfn 25..6, c 5..3, d 2, v 1, g 0
    function automatic logic [31:0] entrylo(input tlb_page_t p, input logic g);
        return {6'b0, p.pfn, p.c, p.d, p.v, g};
    endfunction

    task automatic load_entry(input vpn2_t vpn2, input asid_t asid, input logic g,
                              input tlb_page_t pg0, input tlb_page_t pg1);
        cp0_write(`CP0_ENTRYHI, {vpn2, 5'b0, asid});
        cp0_write(`CP0_ENTRYLO0, entrylo(pg0, g));
        cp0_write(`CP0_ENTRYLO1, entrylo(pg1, g));
    endtask

    task automatic expect_hit(input string port, input logic [31:0] va, input tlb_page_t pg,
                              input logic found, input logic [31:0] pa, input logic v,
                              input logic d, input cattr_t c);
        check_bit({port, " found"}, 1'b1, found);
        check_word({port, " paddr"}, {pg.pfn, va[11:0]}, pa);
        check_bit({port, " v"}, pg.v, v);
        check_bit({port, " d"}, pg.d, d);
        check_attr({port, " c"}, pg.c, c);
    endtask

    task automatic write_readback(input string what, input logic [4:0] addr,
                                  input logic [31:0] mask);
        logic [31:0] w;
        logic [31:0] rd;
        w = $urandom;
        cp0_write(addr, w);
        cp0_read(addr, rd);
        check_word(what, w & mask, rd);
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        start_test("reset_state");
        repeat (10) @(posedge aclk);
        rst_n <= 1'b1;
        #20;
        check_word("random", 32'd15, cp0_rdata);  // raddr preset before release
        cp0_read(`CP0_INDEX, rd);
        check_word("index", 32'd0, rd);
        cp0_read(`CP0_ENTRYHI, rd);
        check_word("entryhi", 32'd0, rd);
        cp0_read(`CP0_ENTRYLO0, rd);
        check_word("entrylo0", 32'd0, rd);
        cp0_read(`CP0_ENTRYLO1, rd);
        check_word("entrylo1", 32'd0, rd);
        translate({rand_vpn2(7), 13'h1abc}, {rand_vpn2(5), 13'h0123});
        check_bit("inst found", 1'b0, inst_found);
        check_bit("data found", 1'b0, data_found);
        // pair 0 hits the zeroed entries, all invalid
        translate(32'h0000_0abc, 32'h0000_1def);
        check_bit("inst v, pair 0", 1'b0, inst_v);
        check_bit("data v, pair 0", 1'b0, data_v);
        end_test();
    endtask

    task automatic test_reg_access();
        logic [31:0] rd;
        tlb_idx_t    r0;
        start_test("reg_access");
        write_readback("entryhi", `CP0_ENTRYHI, 32'hffff_e0ff);
        write_readback("entrylo0", `CP0_ENTRYLO0, 32'h03ff_ffff);
        write_readback("entrylo1", `CP0_ENTRYLO1, 32'h03ff_ffff);
        write_readback("index", `CP0_INDEX, 32'h8000_000f);
        cp0_read(`CP0_RANDOM, rd);
        r0 = rd[3:0];
        cp0_write(`CP0_RANDOM, {28'b0, r0 + 4'd7});
        #20;
        check_idx("random after write", r0 - 4'd2, cp0_rdata[3:0]);  // two edges later
        check_word("random upper bits", 32'd0, cp0_rdata & 32'hffff_fff0);
        end_test();
    endtask

    task automatic test_write_translate();
        logic [11:0] off;
        logic [31:0] va_even;
        logic [31:0] va_odd;
        start_test("write_translate");
        map_vpn2 = rand_vpn2(1);
        map_asid = asid_t'($urandom);
        map_idx  = tlb_idx_t'($urandom);
        map_even = rand_page();
        map_odd  = rand_page();
        load_entry(map_vpn2, map_asid, 1'b0, map_even, map_odd);
        cp0_write(`CP0_INDEX, {28'b0, map_idx});
        pulse_ops(1'b1, 1'b0, 1'b0);
        off     = $urandom;
        va_even = {map_vpn2, 1'b0, off};
        va_odd  = {map_vpn2, 1'b1, ~off};
        translate(va_even, va_odd);
        expect_hit("inst", va_even, map_even, inst_found, inst_paddr, inst_v, inst_d,
                   inst_c);
        expect_hit("data", va_odd, map_odd, data_found, data_paddr, data_v, data_d,
                   data_c);
        translate(va_odd, va_even);
        expect_hit("inst", va_odd, map_odd, inst_found, inst_paddr, inst_v, inst_d,
                   inst_c);
        expect_hit("data", va_even, map_even, data_found, data_paddr, data_v, data_d,
                   data_c);
        end_test();
    endtask

    task automatic test_asid_global();
        vpn2_t     g_vpn2;
        tlb_page_t g_page;
        start_test("asid_global");
        g_vpn2 = rand_vpn2(2);
        g_page = rand_page();
        load_entry(g_vpn2, asid_t'($urandom), 1'b1, g_page, g_page);
        cp0_write(`CP0_INDEX, {28'b0, map_idx ^ 4'd5});  // slot apart from map_idx
        pulse_ops(1'b1, 1'b0, 1'b0);
        cp0_write(`CP0_ENTRYHI, {g_vpn2, 5'b0, map_asid ^ 8'h5a});
        translate({map_vpn2, 13'h0}, {g_vpn2, 13'h1123});
        check_bit("inst found, other asid", 1'b0, inst_found);
        expect_hit("data", {g_vpn2, 13'h1123}, g_page, data_found, data_paddr, data_v,
                   data_d, data_c);
        cp0_write(`CP0_ENTRYHI, {map_vpn2, 5'b0, map_asid});
        translate({map_vpn2, 13'h0}, {g_vpn2, 13'h1123});
        check_bit("inst found, own asid", 1'b1, inst_found);
        check_bit("data found, own asid", 1'b1, data_found);
        end_test();
    endtask

    task automatic test_probe();
        logic [31:0] rd;
        start_test("probe");
        cp0_write(`CP0_ENTRYHI, {map_vpn2, 5'b0, map_asid});
        pulse_ops(1'b0, 1'b0, 1'b1);
        cp0_read(`CP0_INDEX, rd);
        check_word("index on hit", {28'b0, map_idx}, rd);
        cp0_write(`CP0_ENTRYHI, {rand_vpn2(3), 5'b0, map_asid});
        pulse_ops(1'b0, 1'b0, 1'b1);
        cp0_read(`CP0_INDEX, rd);
        check_word("index on miss", {1'b1, 27'b0, map_idx}, rd);  // index bits kept
        end_test();
    endtask

    task automatic test_random_write();
        logic [31:0] rd;
        tlb_idx_t    r0;
        start_test("random_write");
        load_entry(rand_vpn2(6), map_asid, 1'b0, rand_page(), rand_page());
        @(posedge aclk);
        cp0_raddr <= `CP0_RANDOM;
        op_tlbwr  <= 1'b1;
        #20;
        r0 = cp0_rdata[3:0];  // value the write uses
        @(posedge aclk);
        op_tlbwr <= 1'b0;
        #20;
        check_idx("random next cycle", r0 - 4'd1, cp0_rdata[3:0]);
        pulse_ops(1'b0, 1'b0, 1'b1);
        cp0_read(`CP0_INDEX, rd);
        check_word("index after probe", {28'b0, r0}, rd);
        end_test();
    endtask

    initial begin
        void'($urandom(30136));
        rst_n      <= 1'b0;
        inst_vaddr <= '0;
        data_vaddr <= '0;
        cp0_wen    <= 1'b0;
        cp0_waddr  <= '0;
        cp0_wdata  <= '0;
        cp0_raddr  <= `CP0_RANDOM;
        op_tlbwi   <= 1'b0;
        op_tlbwr   <= 1'b0;
        op_tlbp    <= 1'b0;
        test_reset_state();
        test_reg_access();
        test_write_translate();
        test_asid_global();
        test_probe();
        test_random_write();
        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/tlb_pkg.sv
verilog/tlb_match.sv
verilog/tlb_array.sv
verilog/tlb_cp0_regs.sv
verilog/tlb_top.sv
bench/tlb_tb.sv
